//--- hw/dispatch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clr,

    input  logic                  in_valid,
    output logic                  in_ready,
    input  rename_pkg::instr_t    in_instr,

    output rename_pkg::name_t     rs1,
    output rename_pkg::name_t     rs2,
    input  rename_pkg::operand_t  rs1_src,
    input  rename_pkg::operand_t  rs2_src,

    output logic                  alloc_valid,
    input  logic                  alloc_ready,
    input  rename_pkg::nick_t     alloc_nick,

    output rename_pkg::nick_t     lookup_nick1,
    output rename_pkg::nick_t     lookup_nick2,
    input  logic                  lookup_ready1,
    input  logic                  lookup_ready2,
    input  rename_pkg::data_t     lookup_data1,
    input  rename_pkg::data_t     lookup_data2,

    output logic                  out_valid,
    input  logic                  out_ready,
    output rename_pkg::dispatch_t out_disp
);
    import rename_pkg::*;

    logic      accept;
    dispatch_t next_disp;

    // No instruction enters during a flush.
    assign alloc_valid = in_valid && (!out_valid || out_ready) && !clr;
    assign in_ready    = (!out_valid || out_ready) && alloc_ready && !clr;
    assign accept      = alloc_valid && alloc_ready;

    assign rs1          = in_instr.rs1;
    assign rs2          = in_instr.rs2;
    assign lookup_nick1 = rs1_src.nick;
    assign lookup_nick2 = rs2_src.nick;

    // A pending producer that has already finished is resolved here.
    function automatic operand_t resolve(operand_t src, logic ready, data_t data);
        operand_t op;
        op = src;
        if (src.nick != '0 && ready) begin
            op.nick = '0;
            op.data = data;
        end
        return op;
    endfunction

    always_comb begin
        next_disp.op   = in_instr.op;
        next_disp.rd   = in_instr.rd;
        next_disp.pc   = in_instr.pc;
        next_disp.imm  = in_instr.imm;
        next_disp.pd   = in_instr.pd;
        next_disp.nick = renames(in_instr) ? alloc_nick : '0;
        next_disp.src1 = resolve(rs1_src, lookup_ready1, lookup_data1);
        next_disp.src2 = resolve(rs2_src, lookup_ready2, lookup_data2);
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_disp <= next_disp; // Held while the consumer stalls.
        end
    end

endmodule

`default_nettype wire

//--- hw/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 clr,

    input  rename_pkg::name_t    rs1,
    input  rename_pkg::name_t    rs2,
    output rename_pkg::operand_t rs1_src,
    output rename_pkg::operand_t rs2_src,

    input  logic                 rename_valid,
    input  rename_pkg::name_t    rename_rd,
    input  rename_pkg::nick_t    rename_nick,

    input  logic                 commit_valid,
    input  rename_pkg::commit_t  commit
);
    import rename_pkg::*;

    data_t reg_data [reg_num];
    nick_t reg_nick [reg_num];

    function automatic operand_t read_port(name_t name);
        operand_t op;
        if (name == '0) begin
            op.nick = '0;
            op.data = '0;
        end else begin
            op.nick = reg_nick[name];
            op.data = reg_data[name];
        end
        return op;
    endfunction

    always_comb begin
        rs1_src = read_port(rs1);
        rs2_src = read_port(rs2);
    end

    // ------------------------------------------------------------
    // Commit and rename writes
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_num; i++) begin
                reg_data[i] <= '0;
                reg_nick[i] <= '0;
            end
        end else begin
            // Retired values are kept across a flush.
            if (commit_valid && commit.writes_rd) begin
                reg_data[commit.rd] <= commit.data;
                if (reg_nick[commit.rd] == commit.nick) begin
                    reg_nick[commit.rd] <= '0; // Producer still the newest one.
                end
            end

            if (clr) begin
                for (int i = 0; i < reg_num; i++) begin
                    reg_nick[i] <= '0;
                end
            end else if (rename_valid) begin
                reg_nick[rename_rd] <= rename_nick; // Overrides a same-cycle clear.
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/rename_core.sv
`timescale 1ns/1ps
`default_nettype none

module rename_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clr,

    input  logic                  in_valid,
    output logic                  in_ready,
    input  rename_pkg::instr_t    in_instr,

    output logic                  out_valid,
    input  logic                  out_ready,
    output rename_pkg::dispatch_t out_disp,

    input  logic                  wb_valid,
    input  rename_pkg::wb_t       wb,

    output logic                  commit_valid,
    output rename_pkg::commit_t   commit
);
    import rename_pkg::*;

    name_t    rs1;
    name_t    rs2;
    operand_t rs1_src;
    operand_t rs2_src;

    logic     alloc_valid;
    logic     alloc_ready;
    nick_t    alloc_nick;

    logic     rename_valid;
    name_t    rename_rd;
    nick_t    rename_nick;

    nick_t    lookup_nick1;
    nick_t    lookup_nick2;
    logic     lookup_ready1;
    logic     lookup_ready2;
    data_t    lookup_data1;
    data_t    lookup_data2;

    dispatch_stage dispatch_i (
        .clk           (clk),
        .rst           (rst),
        .clr           (clr),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_instr      (in_instr),
        .rs1           (rs1),
        .rs2           (rs2),
        .rs1_src       (rs1_src),
        .rs2_src       (rs2_src),
        .alloc_valid   (alloc_valid),
        .alloc_ready   (alloc_ready),
        .alloc_nick    (alloc_nick),
        .lookup_nick1  (lookup_nick1),
        .lookup_nick2  (lookup_nick2),
        .lookup_ready1 (lookup_ready1),
        .lookup_ready2 (lookup_ready2),
        .lookup_data1  (lookup_data1),
        .lookup_data2  (lookup_data2),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_disp      (out_disp)
    );

    regfile regfile_i (
        .clk          (clk),
        .rst          (rst),
        .clr          (clr),
        .rs1          (rs1),
        .rs2          (rs2),
        .rs1_src      (rs1_src),
        .rs2_src      (rs2_src),
        .rename_valid (rename_valid),
        .rename_rd    (rename_rd),
        .rename_nick  (rename_nick),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    reorder_buffer rob_i (
        .clk           (clk),
        .rst           (rst),
        .clr           (clr),
        .alloc_valid   (alloc_valid),
        .alloc         (in_instr),
        .alloc_ready   (alloc_ready),
        .alloc_nick    (alloc_nick),
        .rename_valid  (rename_valid),
        .rename_rd     (rename_rd),
        .rename_nick   (rename_nick),
        .wb_valid      (wb_valid),
        .wb            (wb),
        .lookup_nick1  (lookup_nick1),
        .lookup_nick2  (lookup_nick2),
        .lookup_ready1 (lookup_ready1),
        .lookup_ready2 (lookup_ready2),
        .lookup_data1  (lookup_data1),
        .lookup_data2  (lookup_data2),
        .commit_valid  (commit_valid),
        .commit        (commit)
    );

endmodule

`default_nettype wire

//--- hw/rename_pkg.sv
`default_nettype none

package rename_pkg;

    localparam int xlen      = 32;
    localparam int reg_num   = 32;
    localparam int name_w    = 5;
    localparam int nick_w    = 4;
    localparam int rob_depth = 8;
    localparam int rob_ptr_w = 3;

    typedef logic [xlen-1:0]      data_t;
    typedef logic [name_w-1:0]    name_t;
    typedef logic [nick_w-1:0]    nick_t;
    typedef logic [rob_ptr_w-1:0] rob_idx_t;
    typedef logic [5:0]           op_t;

    // ------------------------------------------------------------
    // Operation codes
    // ------------------------------------------------------------
    localparam op_t op_nop     = 6'd0;
    localparam op_t op_lui     = 6'd1;
    localparam op_t op_auipc   = 6'd2;
    localparam op_t op_jal     = 6'd3;
    localparam op_t op_jalr    = 6'd4;
    localparam op_t op_branch  = 6'd5;
    localparam op_t op_lw      = 6'd6;
    localparam op_t op_sb      = 6'd7;
    localparam op_t op_sh      = 6'd8;
    localparam op_t op_sw      = 6'd9;
    localparam op_t op_alu_imm = 6'd10;
    localparam op_t op_alu_reg = 6'd11;

    typedef struct packed {
        op_t   op;
        name_t rd;
        name_t rs1;
        name_t rs2;
        data_t pc;
        data_t imm;
        logic  pd;
    } instr_t;

    typedef struct packed {
        nick_t nick; // Zero when data is final.
        data_t data;
    } operand_t;

    typedef struct packed {
        op_t      op;
        name_t    rd;
        data_t    pc;
        data_t    imm;
        logic     pd;
        nick_t    nick;
        operand_t src1;
        operand_t src2;
    } dispatch_t;

    typedef struct packed {
        nick_t nick;
        data_t data;
    } wb_t;

    typedef struct packed {
        name_t rd;
        nick_t nick;
        data_t data;
        logic  writes_rd;
    } commit_t;

    // Stores and branches carry an rd field that is not a destination.
    function automatic logic renames(instr_t instr);
        logic no_dest;
        no_dest = (instr.op == op_sb) || (instr.op == op_sh) ||
                  (instr.op == op_sw) || (instr.op == op_branch);
        return !no_dest && (instr.rd != '0);
    endfunction

    function automatic nick_t idx_to_nick(rob_idx_t idx);
        return nick_t'(idx) + nick_t'(1);
    endfunction

    function automatic rob_idx_t nick_to_idx(nick_t nick);
        nick_t k;
        k = nick - nick_t'(1);
        return k[rob_ptr_w-1:0];
    endfunction

endpackage

`default_nettype wire

//--- hw/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                clr,

    input  logic                alloc_valid,
    input  rename_pkg::instr_t  alloc,
    output logic                alloc_ready,
    output rename_pkg::nick_t   alloc_nick,

    output logic                rename_valid,
    output rename_pkg::name_t   rename_rd,
    output rename_pkg::nick_t   rename_nick,

    input  logic                wb_valid,
    input  rename_pkg::wb_t     wb,

    input  rename_pkg::nick_t   lookup_nick1,
    input  rename_pkg::nick_t   lookup_nick2,
    output logic                lookup_ready1,
    output logic                lookup_ready2,
    output rename_pkg::data_t   lookup_data1,
    output rename_pkg::data_t   lookup_data2,

    output logic                commit_valid,
    output rename_pkg::commit_t commit
);
    import rename_pkg::*;

    name_t ent_rd     [rob_depth];
    logic  ent_writes [rob_depth];
    logic  ent_done   [rob_depth];
    data_t ent_data   [rob_depth];

    rob_idx_t             head;
    rob_idx_t             tail;
    logic [rob_ptr_w:0]   count;
    logic                 alloc_fire;
    rob_idx_t             wb_idx;

    assign alloc_ready = (count != rob_depth);
    assign alloc_fire  = alloc_valid && alloc_ready;
    assign alloc_nick  = idx_to_nick(tail);

    assign rename_valid = alloc_fire && renames(alloc);
    assign rename_rd    = alloc.rd;
    assign rename_nick  = alloc_nick;

    assign wb_idx = nick_to_idx(wb.nick);

    // Head retires once its result has been written back.
    assign commit_valid     = (count != '0) && ent_done[head];
    assign commit.rd        = ent_rd[head];
    assign commit.nick      = idx_to_nick(head);
    assign commit.data      = ent_data[head];
    assign commit.writes_rd = ent_writes[head];

    // ------------------------------------------------------------
    // Operand lookup, with bypass of this cycle's writeback
    // ------------------------------------------------------------
    function automatic logic look_ready(nick_t nick);
        if (nick == '0) begin
            return 1'b0;
        end
        return ent_done[nick_to_idx(nick)] || (wb_valid && wb.nick == nick);
    endfunction

    function automatic data_t look_data(nick_t nick);
        if (wb_valid && wb.nick == nick) begin
            return wb.data;
        end
        return ent_data[nick_to_idx(nick)];
    endfunction

    always_comb begin
        lookup_ready1 = look_ready(lookup_nick1);
        lookup_ready2 = look_ready(lookup_nick2);
        lookup_data1  = look_data(lookup_nick1);
        lookup_data2  = look_data(lookup_nick2);
    end

    // ------------------------------------------------------------
    // Pointers and entry state
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || clr) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rob_depth; i++) begin
                ent_done[i] <= 1'b0;
            end
        end else begin
            if (alloc_fire) begin
                ent_done[tail] <= 1'b0;
                tail           <= tail + 1'b1;
            end
            if (wb_valid) begin
                ent_done[wb_idx] <= 1'b1; // Never the slot being allocated.
            end
            if (commit_valid) begin
                head <= head + 1'b1;
            end
            unique case ({alloc_fire, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            ent_rd[tail]     <= alloc.rd;
            ent_writes[tail] <= renames(alloc);
        end
        if (wb_valid) begin
            ent_data[wb_idx] <= wb.data;
        end
    end

endmodule

`default_nettype wire

//--- rename_core.f
hw/rename_pkg.sv
hw/regfile.sv
hw/reorder_buffer.sv
hw/dispatch_stage.sv
hw/rename_core.sv
tb/clk_gen.sv
tb/rename_core_tb.sv

//--- tb/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset covers the first two rising edges.
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- tb/rename_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rename_core_tb;
    import rename_pkg::*;

    // Phases take roughly 10, 15, 400, 40, 40 and 25 cycles.
    localparam int expected_cycles = 550;
    localparam int cycle_limit     = 4 * expected_cycles;

    logic      clk;
    logic      rst;
    logic      clr;
    logic      in_valid;
    logic      in_ready;
    instr_t    in_instr;
    logic      out_valid;
    logic      out_ready;
    dispatch_t out_disp;
    logic      wb_valid;
    wb_t       wb;
    logic      commit_valid;
    commit_t   commit;

    clk_gen clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    rename_core dut_i (
        .clk          (clk),
        .rst          (rst),
        .clr          (clr),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_instr     (in_instr),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_disp     (out_disp),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    // ----------------------------------------------------------
    // Reference model of registers, nicks and in-flight entries
    // ----------------------------------------------------------
    data_t     m_reg  [reg_num];
    nick_t     m_nick [reg_num];
    name_t     m_rd   [rob_depth];
    logic      m_wr   [rob_depth];
    logic      m_done [rob_depth];
    data_t     m_val  [rob_depth];
    rob_idx_t  m_head;
    rob_idx_t  m_tail;
    int        m_count;
    logic      exp_pending;   // Output register holds a record.
    dispatch_t exp_out;
    logic      exp_commit_valid;
    commit_t   exp_commit;
    logic      accept;
    int        cycles = 0;
    int        wb_mode;       // 0 none, 1 random entry, 2 oldest entry.
    logic      ready_rand;
    logic      ready_level;

    assign accept = in_valid && in_ready;

    // x0, stores and branches never take a nick.
    function automatic logic writes_dest(instr_t i);
        if (i.op == op_sb || i.op == op_sh || i.op == op_sw || i.op == op_branch) begin
            return 1'b0;
        end
        return i.rd != '0;
    endfunction

    function automatic operand_t expect_src(name_t r);
        operand_t s;
        rob_idx_t k;
        s.nick = '0;
        s.data = '0;
        if (r != '0) begin
            s.nick = m_nick[r];
            s.data = m_reg[r];
            k = rob_idx_t'(s.nick - 4'd1);
            if (s.nick != '0 && wb_valid && wb.nick == s.nick) begin
                s.nick = '0;
                s.data = wb.data;   // Writeback in the accept cycle.
            end else if (s.nick != '0 && m_done[k]) begin
                s.nick = '0;
                s.data = m_val[k];
            end
        end
        return s;
    endfunction

    function automatic dispatch_t expect_disp(instr_t i);
        dispatch_t d;
        d.op   = i.op;
        d.rd   = i.rd;
        d.pc   = i.pc;
        d.imm  = i.imm;
        d.pd   = i.pd;
        d.nick = writes_dest(i) ? nick_t'(m_tail) + 4'd1 : '0;
        d.src1 = expect_src(i.rs1);
        d.src2 = expect_src(i.rs2);
        return d;
    endfunction

    function automatic logic commit_matches(commit_t got, commit_t want);
        if (got.writes_rd !== want.writes_rd || got.nick !== want.nick ||
            got.data !== want.data) begin
            return 1'b0;
        end
        return !want.writes_rd || got.rd === want.rd;
    endfunction

    always_comb begin
        exp_commit_valid     = (m_count != 0) && m_done[m_head];
        exp_commit.rd        = m_rd[m_head];
        exp_commit.nick      = nick_t'(m_head) + 4'd1;
        exp_commit.data      = m_val[m_head];
        exp_commit.writes_rd = m_wr[m_head];
    end

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_num; i++) begin
                m_reg[i]  <= '0;
                m_nick[i] <= '0;
            end
            for (int i = 0; i < rob_depth; i++) begin
                m_done[i] <= 1'b0;
            end
            m_head      <= '0;
            m_tail      <= '0;
            m_count     <= 0;
            exp_pending <= 1'b0;
        end else begin
            if (exp_commit_valid && exp_commit.writes_rd) begin
                m_reg[exp_commit.rd] <= exp_commit.data;
                if (m_nick[exp_commit.rd] == exp_commit.nick) begin
                    m_nick[exp_commit.rd] <= '0;
                end
            end
            if (clr) begin
                for (int i = 0; i < reg_num; i++) begin
                    m_nick[i] <= '0;
                end
                for (int i = 0; i < rob_depth; i++) begin
                    m_done[i] <= 1'b0;
                end
                m_head      <= '0;
                m_tail      <= '0;
                m_count     <= 0;
                exp_pending <= 1'b0;
            end else begin
                if (wb_valid) begin
                    m_done[rob_idx_t'(wb.nick - 4'd1)] <= 1'b1;
                    m_val[rob_idx_t'(wb.nick - 4'd1)]  <= wb.data;
                end
                if (accept) begin
                    exp_out        <= expect_disp(in_instr);
                    m_rd[m_tail]   <= in_instr.rd;
                    m_wr[m_tail]   <= writes_dest(in_instr);
                    m_done[m_tail] <= 1'b0;
                    m_tail         <= m_tail + 1'b1;
                    if (writes_dest(in_instr)) begin
                        m_nick[in_instr.rd] <= nick_t'(m_tail) + 4'd1; // Wins over a clear.
                    end
                end
                if (exp_commit_valid) begin
                    m_head <= m_head + 1'b1;
                end
                m_count <= m_count + int'(accept) - int'(exp_commit_valid);
                if (accept) begin
                    exp_pending <= 1'b1;
                end else if (out_ready) begin
                    exp_pending <= 1'b0;
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    a_in_ready: assert property (@(posedge clk) disable iff (rst || clr)
            in_ready === ((!exp_pending || out_ready) && (m_count != rob_depth)))
        else stop_with_failure($sformatf("[FAIL] %0t ns: in_ready is wrong", $time));

    a_out_valid: assert property (@(posedge clk) disable iff (rst)
            out_valid === exp_pending)
        else stop_with_failure($sformatf("[FAIL] %0t ns: record lost or duplicated", $time));

    a_out_disp: assert property (@(posedge clk) disable iff (rst)
            out_valid |-> out_disp === exp_out)
        else stop_with_failure($sformatf("[FAIL] %0t ns: out_disp differs from model", $time));

    a_hold: assert property (@(posedge clk) disable iff (rst || clr)
            out_valid && !out_ready |=> $stable(out_disp))
        else stop_with_failure($sformatf("[FAIL] %0t ns: out_disp changed in a stall", $time));

    a_flush: assert property (@(posedge clk) disable iff (rst)
            clr |=> !out_valid && !commit_valid)
        else stop_with_failure($sformatf("[FAIL] %0t ns: activity after clr", $time));

    a_commit_valid: assert property (@(posedge clk) disable iff (rst)
            commit_valid === exp_commit_valid)
        else stop_with_failure($sformatf("[FAIL] %0t ns: commit_valid is wrong", $time));

    a_commit: assert property (@(posedge clk) disable iff (rst)
            commit_valid |-> commit_matches(commit, exp_commit))
        else stop_with_failure($sformatf("[FAIL] %0t ns: commit differs from model", $time));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            stop_with_failure($sformatf("Timeout: the run did not finish within %0d cycles",
                                        cycle_limit));
        end
    end

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    function automatic instr_t make_instr(op_t op, name_t rd, name_t rs1, name_t rs2);
        instr_t i;
        i.op  = op;
        i.rd  = rd;
        i.rs1 = rs1;
        i.rs2 = rs2;
        i.pc  = $urandom & 32'hffff_fffc;
        i.imm = $urandom;
        i.pd  = 1'($urandom % 2);
        return i;
    endfunction

    // Few registers, so that readers often hit a pending producer.
    function automatic instr_t random_instr();
        return make_instr(op_t'($urandom % 12), name_t'($urandom % 8),
                          name_t'($urandom % 8), name_t'($urandom % 8));
    endfunction

    task automatic drive_wb(input int mode);
        int cand[$];
        int k;
        for (int i = 0; i < m_count; i++) begin
            k = (int'(m_head) + i) % rob_depth;
            if (!m_done[k] && !(wb_valid && wb.nick == nick_t'(k + 1))) begin
                cand.push_back(k);
            end
        end
        if (mode == 0 || cand.size() == 0 || (mode == 1 && $urandom % 3 == 0)) begin
            wb_valid <= 1'b0;
        end else begin
            k = (mode == 1) ? cand[$urandom % cand.size()] : cand[0];
            wb_valid <= 1'b1;
            wb.nick  <= nick_t'(k + 1);
            wb.data  <= $urandom;
        end
    endtask

    task automatic drive_side();
        drive_wb(wb_mode);
        if (ready_rand) begin
            out_ready <= ($urandom % 4) != 0;
        end else begin
            out_ready <= ready_level;
        end
    endtask

    task automatic cycle();
        @(posedge clk);
        drive_side();
    endtask

    task automatic issue(input instr_t instr);
        logic taken;
        in_valid <= 1'b1;
        in_instr <= instr;
        taken = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = in_ready;
            drive_side();
        end
        in_valid <= 1'b0;
    endtask

    task automatic drain();
        wb_mode = 1;
        while (m_count != 0 || exp_pending) begin
            cycle();
        end
    endtask

    initial begin
        void'($urandom(32'h8e03_090e));
        clr         = 1'b0;
        in_valid    = 1'b0;
        in_instr    = '0;
        out_ready   = 1'b0;
        wb_valid    = 1'b0;
        wb          = '0;
        wb_mode     = 0;
        ready_rand  = 1'b0;
        ready_level = 1'b1;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end

        issue(random_instr());   // Fresh registers read as zero.
        issue(random_instr());
        drain();

        // Producer of x5 and readers before, during and after its result.
        wb_mode = 0;
        issue(make_instr(op_alu_imm, 5'd5, 5'd0, 5'd0));
        issue(make_instr(op_alu_reg, 5'd6, 5'd5, 5'd5));
        drive_wb(2);
        issue(make_instr(op_alu_reg, 5'd8, 5'd5, 5'd1));
        issue(make_instr(op_alu_reg, 5'd9, 5'd5, 5'd2));
        issue(make_instr(op_alu_reg, 5'd10, 5'd5, 5'd3));
        drain();

        ready_rand = 1'b1;
        repeat (200) issue(random_instr());
        drain();

        // Fill the buffer with writebacks withheld.
        wb_mode    = 0;
        ready_rand = 1'b0;
        repeat (rob_depth) issue(random_instr());
        ready_rand = 1'b1;
        in_valid <= 1'b1;
        in_instr <= random_instr();
        repeat (10) cycle();
        assert (m_count == rob_depth)
            else stop_with_failure($sformatf("[FAIL] %0t ns: %0d entries held, not %0d",
                                             $time, m_count, rob_depth));
        wb_mode = 1;
        issue(in_instr);
        drain();

        // Flush with a record held and an entry in flight.
        wb_mode     = 0;
        ready_rand  = 1'b0;
        ready_level = 1'b0;
        issue(make_instr(op_lui, 5'd1, 5'd0, 5'd0));
        clr <= 1'b1;
        cycle();
        clr <= 1'b0;
        ready_level = 1'b1;
        wb_mode     = 1;
        for (int r = 0; r < reg_num; r += 2) begin
            issue(make_instr(op_sw, 5'd0, name_t'(r), name_t'(r + 1)));
        end
        drain();

        // x7 renamed twice, so the older commit leaves the newer nick.
        wb_mode = 0;
        issue(make_instr(op_alu_imm, 5'd7, 5'd0, 5'd0));
        issue(make_instr(op_alu_imm, 5'd7, 5'd0, 5'd0));
        drive_wb(2);
        repeat (3) cycle();
        issue(make_instr(op_alu_reg, 5'd11, 5'd7, 5'd0));
        drain();
        issue(make_instr(op_alu_reg, 5'd12, 5'd7, 5'd7));
        drain();

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire
